/* project.f */
hdl/lsu_pkg.sv
hdl/data_sram.sv
hdl/lsu_stage.sv
hdl/wb_stage.sv
hdl/lsu_subsys.sv
sim/lsu_subsys_chk.sv
sim/tb_lsu_subsys.sv

/* Bender.yml */
package:
  name: lsu_subsys

sources:
  - files:
      - hdl/lsu_pkg.sv
      - hdl/data_sram.sv
      - hdl/lsu_stage.sv
      - hdl/wb_stage.sv
      - hdl/lsu_subsys.sv
  - target: simulation
    files:
      - sim/lsu_subsys_chk.sv
      - sim/tb_lsu_subsys.sv

/* sim/tb_lsu_subsys.sv */
/* Drives lsu_subsys with directed and xorshift-random operations and checks
   each commit against a byte-addressed memory and register model. */
`timescale 1ns/1ps

module tb_lsu_subsys;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 3;
    localparam int N_DIRECTED      = 18;
    localparam int N_RANDOM        = 400;
    localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 8 + RESET_CYCLES;

    logic             clk;
    logic             rst;
    lsu_pkg::lsu_op_s op_i;
    logic             op_valid_i;
    logic             op_ready_o;
    lsu_pkg::commit_s commit_o;
    logic             commit_valid_o;

    // reference state
    logic [7:0]       ref_mem [1024];
    logic [31:0]      ref_regs [32];
    logic [31:0]      rng_state;

    lsu_subsys lsu_subsys_inst (
        .clk            (clk),
        .rst            (rst),
        .op_i           (op_i),
        .op_valid_i     (op_valid_i),
        .op_ready_o     (op_ready_o),
        .commit_o       (commit_o),
        .commit_valid_o (commit_valid_o)
    );

    bind lsu_subsys lsu_subsys_chk lsu_subsys_chk_inst (
        .clk            (clk),
        .rst            (rst),
        .op_ready_i     (op_ready_o),
        .wb_valid_i     (wb_valid),
        .wb_ready_i     (wb_ready),
        .wb_req_i       (wb_req),
        .commit_valid_i (commit_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("run timed out after %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    // stop at the first assertion failure of the bound checker
    initial begin
        wait (lsu_subsys_inst.lsu_subsys_chk_inst.assert_failures != 0);
        $display("assertion checker reported a failure");
        $display("TEST FAILED");
        $fatal(1, "assertion failure");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_ready(input bit exp, input string where);
        if (op_ready_o !== exp) begin
            report_mismatch($sformatf("op_ready_o is %b, expected %b (%s)",
                                      op_ready_o, exp, where));
        end
    endtask

    task automatic check_commit(input lsu_pkg::commit_s exp, input bit exp_valid);
        if (commit_valid_o !== exp_valid) begin
            report_mismatch($sformatf("commit_valid_o is %b, expected %b",
                                      commit_valid_o, exp_valid));
        end else if (exp_valid && (commit_o !== exp)) begin
            report_mismatch($sformatf("commit x%0d = %h, expected x%0d = %h",
                                      commit_o.rd, commit_o.data, exp.rd, exp.data));
        end
    endtask

    // model of one operation in little-endian byte order
    task automatic predict_op(input lsu_pkg::lsu_op_s op, output bit exp_valid,
                              output lsu_pkg::commit_s exp);
        logic [31:0] value;
        logic [31:0] src;
        int          b;
        b     = op.addr[9:0];
        value = op.addr;
        src   = (op.rs2 == 5'd0) ? 32'h0 : ref_regs[op.rs2];
        case (op.store_type)
            lsu_pkg::STORE_SB: ref_mem[b] = src[7:0];
            lsu_pkg::STORE_SH: {ref_mem[b + 1], ref_mem[b]} = src[15:0];
            lsu_pkg::STORE_SW: {ref_mem[b + 3], ref_mem[b + 2],
                                ref_mem[b + 1], ref_mem[b]} = src;
            default: ;
        endcase
        case (op.load_type)
            lsu_pkg::LOAD_LB:  value = $signed(ref_mem[b]);
            lsu_pkg::LOAD_LBU: value = {24'h0, ref_mem[b]};
            lsu_pkg::LOAD_LH:  value = $signed({ref_mem[b + 1], ref_mem[b]});
            lsu_pkg::LOAD_LHU: value = {16'h0, ref_mem[b + 1], ref_mem[b]};
            lsu_pkg::LOAD_LW:  value = {ref_mem[b + 3], ref_mem[b + 2],
                                        ref_mem[b + 1], ref_mem[b]};
            default: ;
        endcase
        exp_valid = (op.store_type == lsu_pkg::STORE_NONE) && op.wd && (op.rd != 5'd0);
        exp.rd    = op.rd;
        exp.data  = value;
        if (exp_valid) begin
            ref_regs[op.rd] = value;
        end
    endtask

    // drive one operation and follow it to its commit slot
    task automatic run_op(input lsu_pkg::lsu_op_s op, input int gap);
        bit               exp_valid;
        lsu_pkg::commit_s exp;
        exp = '0;
        repeat (gap) begin
            @(posedge clk);
            #1;
            @(negedge clk);
            check_ready(1'b1, "idle gap");
            check_commit(exp, 1'b0);
        end
        @(posedge clk);
        #1;
        op_i       = op;
        op_valid_i = 1'b1;
        @(negedge clk);
        while (!op_ready_o) begin
            @(negedge clk);
        end
        predict_op(op, exp_valid, exp);
        @(posedge clk);
        #1;
        op_valid_i = 1'b0;
        for (int k = 0; k < 3; k++) begin
            @(negedge clk);
            check_ready(1'b0, "operation in flight");
            check_commit(exp, 1'b0);
        end
        @(negedge clk);
        check_commit(exp, exp_valid);
        check_ready(!exp_valid, "cycle after writeback transfer");
        if (exp_valid) begin
            @(negedge clk);
            check_ready(1'b1, "cycle after commit");
            check_commit(exp, 1'b0);
        end
    endtask

    task automatic issue_op(input lsu_pkg::load_type_e lt, input lsu_pkg::store_type_e st,
                            input logic [31:0] addr, input logic [4:0] rs2,
                            input logic [4:0] rd, input logic wd);
        lsu_pkg::lsu_op_s op;
        op.addr       = addr;
        op.load_type  = lt;
        op.store_type = st;
        op.rs2        = rs2;
        op.rd         = rd;
        op.wd         = wd;
        run_op(op, 0);
    endtask

    task automatic gen_random_op(output lsu_pkg::lsu_op_s op, output int gap);
        logic [31:0] r;
        int          size;
        op   = '0;
        size = 4;
        draw(r);
        case (r % 9)
            0: begin
                op.load_type = lsu_pkg::LOAD_LB;
                size         = 1;
            end
            1: begin
                op.load_type = lsu_pkg::LOAD_LBU;
                size         = 1;
            end
            2: begin
                op.load_type = lsu_pkg::LOAD_LH;
                size         = 2;
            end
            3: begin
                op.load_type = lsu_pkg::LOAD_LHU;
                size         = 2;
            end
            4: op.load_type = lsu_pkg::LOAD_LW;
            5: begin
                op.store_type = lsu_pkg::STORE_SB;
                size          = 1;
            end
            6: begin
                op.store_type = lsu_pkg::STORE_SH;
                size          = 2;
            end
            7: op.store_type = lsu_pkg::STORE_SW;
            default: size = 0;
        endcase
        draw(r);
        // mostly a small window so that loads hit earlier stores
        if (size == 0) begin
            op.addr = r;
        end else if (r[31:29] != 3'd0) begin
            op.addr = {26'h0, r[5:0]};
        end else begin
            op.addr = {22'h0, r[9:0]};
        end
        if (size == 2) begin
            op.addr[0] = 1'b0;
        end
        if (size == 4) begin
            op.addr[1:0] = 2'b00;
        end
        draw(r);
        op.rs2 = r[4:0];
        op.rd  = r[9:5];
        op.wd  = (r[12:10] != 3'd0);
        gap    = (r[15:13] == 3'd0) ? 1 + r[16] : 0;
    endtask

    initial begin : main
        lsu_pkg::lsu_op_s op;
        int               gap;
        rst        = 1'b1;
        op_valid_i = 1'b0;
        op_i       = '0;
        rng_state  = 32'h2a67_d1f2;
        foreach (ref_mem[i]) ref_mem[i] = 8'h0;
        foreach (ref_regs[i]) ref_regs[i] = 32'h0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_ready(1'b1, "after reset");
            check_commit('0, 1'b0);
        end

        // word store and load back followed by sub-word merges
        issue_op(lsu_pkg::LOAD_NONE, lsu_pkg::STORE_NONE, 32'hdead_beef, 5'd0, 5'd5, 1'b1);
        issue_op(lsu_pkg::LOAD_NONE, lsu_pkg::STORE_SW, 32'h40, 5'd5, 5'd0, 1'b0);
        issue_op(lsu_pkg::LOAD_LW, lsu_pkg::STORE_NONE, 32'h40, 5'd0, 5'd6, 1'b1);
        issue_op(lsu_pkg::LOAD_NONE, lsu_pkg::STORE_NONE, 32'h1234_c3a5, 5'd0, 5'd7, 1'b1);
        issue_op(lsu_pkg::LOAD_NONE, lsu_pkg::STORE_SB, 32'h41, 5'd7, 5'd0, 1'b0);
        issue_op(lsu_pkg::LOAD_NONE, lsu_pkg::STORE_SH, 32'h42, 5'd7, 5'd0, 1'b0);
        issue_op(lsu_pkg::LOAD_LW, lsu_pkg::STORE_NONE, 32'h40, 5'd0, 5'd8, 1'b1);

        // sign and zero extension of each lane
        issue_op(lsu_pkg::LOAD_LB, lsu_pkg::STORE_NONE, 32'h41, 5'd0, 5'd9, 1'b1);
        issue_op(lsu_pkg::LOAD_LBU, lsu_pkg::STORE_NONE, 32'h41, 5'd0, 5'd9, 1'b1);
        issue_op(lsu_pkg::LOAD_LH, lsu_pkg::STORE_NONE, 32'h42, 5'd0, 5'd10, 1'b1);
        issue_op(lsu_pkg::LOAD_LHU, lsu_pkg::STORE_NONE, 32'h42, 5'd0, 5'd10, 1'b1);
        issue_op(lsu_pkg::LOAD_LB, lsu_pkg::STORE_NONE, 32'h40, 5'd0, 5'd11, 1'b1);
        issue_op(lsu_pkg::LOAD_LBU, lsu_pkg::STORE_NONE, 32'h43, 5'd0, 5'd11, 1'b1);

        // no commit for wd low or rd zero
        issue_op(lsu_pkg::LOAD_NONE, lsu_pkg::STORE_NONE, 32'h0bad_0003, 5'd0, 5'd3, 1'b0);
        issue_op(lsu_pkg::LOAD_NONE, lsu_pkg::STORE_NONE, 32'h0bad_0000, 5'd0, 5'd0, 1'b1);
        // x0 as store data writes zero
        issue_op(lsu_pkg::LOAD_NONE, lsu_pkg::STORE_SW, 32'h44, 5'd5, 5'd0, 1'b0);
        issue_op(lsu_pkg::LOAD_NONE, lsu_pkg::STORE_SW, 32'h44, 5'd0, 5'd0, 1'b0);
        issue_op(lsu_pkg::LOAD_LW, lsu_pkg::STORE_NONE, 32'h44, 5'd0, 5'd12, 1'b1);

        for (int n = 0; n < N_RANDOM; n++) begin
            gen_random_op(op, gap);
            run_op(op, gap);
        end
        repeat (2) @(posedge clk);

        if (lsu_subsys_inst.lsu_subsys_chk_inst.assert_failures == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("assertion checker reported %0d failures",
                     lsu_subsys_inst.lsu_subsys_chk_inst.assert_failures);
            $display("TEST FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

/* sim/lsu_subsys_chk.sv */
/* Concurrent assertions on the internal handshakes and the commit port,
   bound into lsu_subsys by the testbench. */
`timescale 1ns/1ps

module lsu_subsys_chk (
    input logic             clk,
    input logic             rst,
    input logic             op_ready_i,
    input logic             wb_valid_i,
    input logic             wb_ready_i,
    input lsu_pkg::wb_req_s wb_req_i,
    input logic             commit_valid_i
);

    int assert_failures = 0;

    // only one operation in flight
    ready_while_busy: assert property (@(posedge clk) disable iff (rst)
        !(op_ready_i && wb_valid_i))
    else begin
        $error("op_ready_o high while wb_valid is high");
        assert_failures++;
    end

    // stalled request must hold
    stalled_req_stable: assert property (@(posedge clk) disable iff (rst)
        (wb_valid_i && !wb_ready_i) |=> (wb_valid_i && $stable(wb_req_i)))
    else begin
        $error("wb_req changed or dropped while stalled");
        assert_failures++;
    end

    commit_single_cycle: assert property (@(posedge clk) disable iff (rst)
        commit_valid_i |=> !commit_valid_i)
    else begin
        $error("commit_valid_o high for two cycles");
        assert_failures++;
    end

endmodule

/* hdl/lsu_subsys.sv */
/* Top level of the memory-access subsystem: memory stage, data memory and writeback.
   Execute drives op_i with valid/ready; commits come out at commit_o. */
`timescale 1ns/1ps

module lsu_subsys (
    input  logic             clk,
    input  logic             rst,
    input  lsu_pkg::lsu_op_s op_i,
    input  logic             op_valid_i,
    output logic             op_ready_o,
    output lsu_pkg::commit_s commit_o,
    output logic             commit_valid_o
);

    logic [4:0]                 rs2_addr;
    logic [31:0]                rs2_data;
    logic                       mem_en;
    logic [3:0]                 mem_we;
    logic [lsu_pkg::MEM_AW-1:0] mem_addr;
    lsu_pkg::mem_word_u         mem_wdata;
    lsu_pkg::mem_word_u         mem_rdata;
    lsu_pkg::wb_req_s           wb_req;
    logic                       wb_valid;
    logic                       wb_ready;

    lsu_stage lsu_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .op_i        (op_i),
        .op_valid_i  (op_valid_i),
        .op_ready_o  (op_ready_o),
        .rs2_addr_o  (rs2_addr),
        .rs2_data_i  (rs2_data),
        .mem_en_o    (mem_en),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata),
        .wb_req_o    (wb_req),
        .wb_valid_o  (wb_valid),
        .wb_ready_i  (wb_ready)
    );

    data_sram data_sram_inst (
        .clk     (clk),
        .rst     (rst),
        .en_i    (mem_en),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

    wb_stage wb_stage_inst (
        .clk            (clk),
        .rst            (rst),
        .wb_req_i       (wb_req),
        .wb_valid_i     (wb_valid),
        .wb_ready_o     (wb_ready),
        .rs2_addr_i     (rs2_addr),
        .rs2_data_o     (rs2_data),
        .commit_o       (commit_o),
        .commit_valid_o (commit_valid_o)
    );

endmodule

/* hdl/wb_stage.sv */
/* Writeback: register file with an asynchronous store-data read port,
   written on each accepted request, and a one-cycle commit report. */
`timescale 1ns/1ps

module wb_stage (
    input  logic               clk,
    input  logic               rst,
    input  lsu_pkg::wb_req_s   wb_req_i,
    input  logic               wb_valid_i,
    output logic               wb_ready_o,
    input  logic [4:0]         rs2_addr_i,
    output logic [31:0]        rs2_data_o,
    output lsu_pkg::commit_s   commit_o,
    output logic               commit_valid_o
);

    logic [31:0]      regs [lsu_pkg::REG_NUM];
    lsu_pkg::commit_s commit_q;
    logic             commit_valid_q;
    logic             xfer;
    logic             do_write;

    // busy for the cycle the commit is reported
    assign wb_ready_o = !commit_valid_q;
    assign xfer       = wb_valid_i && wb_ready_o;
    assign do_write   = xfer && wb_req_i.wd && (wb_req_i.rd != 5'd0);

    // x0 is hardwired to zero
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? 32'h0 : regs[rs2_addr_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < lsu_pkg::REG_NUM; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (do_write) begin
            regs[wb_req_i.rd] <= wb_req_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid_q <= 1'b0;
        end else begin
            commit_valid_q <= do_write;
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            commit_q.rd   <= wb_req_i.rd;
            commit_q.data <= wb_req_i.data;
        end
    end

    assign commit_o       = commit_q;
    assign commit_valid_o = commit_valid_q;

endmodule

/* hdl/lsu_stage.sv */
/* Memory-access stage: takes one operation from execute, drives the data memory,
   extracts load lanes and hands the result to writeback over valid/ready. */
`timescale 1ns/1ps

module lsu_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  lsu_pkg::lsu_op_s              op_i,
    input  logic                          op_valid_i,
    output logic                          op_ready_o,
    output logic [4:0]                    rs2_addr_o,
    input  logic [31:0]                   rs2_data_i,
    output logic                          mem_en_o,
    output logic [3:0]                    mem_we_o,
    output logic [lsu_pkg::MEM_AW-1:0]    mem_addr_o,
    output lsu_pkg::mem_word_u            mem_wdata_o,
    input  lsu_pkg::mem_word_u            mem_rdata_i,
    output lsu_pkg::wb_req_s              wb_req_o,
    output logic                          wb_valid_o,
    input  logic                          wb_ready_i
);

    logic [1:0]       state_q;
    logic             issued_q;
    lsu_pkg::lsu_op_s op_q;
    lsu_pkg::wb_req_s wb_req_q;
    logic             wb_valid_q;

    logic             accept;
    logic             is_load;
    logic             is_store;
    logic             first_cycle;
    logic [1:0]       lane;
    logic [3:0]       store_mask;
    logic [7:0]       byte_sel;
    logic [15:0]      half_sel;
    logic [31:0]      result;

    // writeback still reporting a commit also holds off the next operation
    assign op_ready_o  = (state_q == lsu_pkg::ST_WAIT_OP) && wb_ready_i;
    assign accept      = op_valid_i && op_ready_o;

    assign is_load     = op_q.load_type != lsu_pkg::LOAD_NONE;
    assign is_store    = op_q.store_type != lsu_pkg::STORE_NONE;
    assign first_cycle = (state_q == lsu_pkg::ST_ACCESS) && !issued_q;
    assign lane        = op_q.addr[1:0];

    assign rs2_addr_o  = op_q.rs2;
    assign mem_addr_o  = op_q.addr[lsu_pkg::MEM_AW+1:2];
    assign mem_en_o    = first_cycle && is_load;
    assign mem_we_o    = first_cycle ? store_mask : 4'b0000;

    // byte mask and lane placement of the store data
    always_comb begin
        store_mask       = 4'b0000;
        mem_wdata_o.word = 32'h0;
        case (op_q.store_type)
            lsu_pkg::STORE_SB: begin
                store_mask              = 4'b0001 << lane;
                mem_wdata_o.lane8[lane] = rs2_data_i[7:0];
            end
            lsu_pkg::STORE_SH: begin
                store_mask                  = 4'b0011 << {lane[1], 1'b0};
                mem_wdata_o.lane16[lane[1]] = rs2_data_i[15:0];
            end
            lsu_pkg::STORE_SW: begin
                store_mask       = 4'b1111;
                mem_wdata_o.word = rs2_data_i;
            end
            default: begin
                store_mask = 4'b0000;
            end
        endcase
    end

    assign byte_sel = mem_rdata_i.lane8[lane];
    assign half_sel = mem_rdata_i.lane16[lane[1]];

    // lane extraction, address pass-through when nothing is loaded
    always_comb begin
        case (op_q.load_type)
            lsu_pkg::LOAD_LB:  result = {{24{byte_sel[7]}}, byte_sel};
            lsu_pkg::LOAD_LH:  result = {{16{half_sel[15]}}, half_sel};
            lsu_pkg::LOAD_LW:  result = mem_rdata_i.word;
            lsu_pkg::LOAD_LBU: result = {24'h0, byte_sel};
            lsu_pkg::LOAD_LHU: result = {16'h0, half_sel};
            default:           result = op_q.addr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= lsu_pkg::ST_WAIT_OP;
            issued_q   <= 1'b0;
            wb_valid_q <= 1'b0;
        end else begin
            case (state_q)
                lsu_pkg::ST_WAIT_OP: begin
                    if (accept) begin
                        state_q  <= lsu_pkg::ST_ACCESS;
                        issued_q <= 1'b0;
                    end
                end
                lsu_pkg::ST_ACCESS: begin
                    // second cycle sees the read data
                    if (!issued_q) begin
                        issued_q <= 1'b1;
                    end else begin
                        state_q    <= lsu_pkg::ST_WAIT_WB;
                        wb_valid_q <= 1'b1;
                    end
                end
                lsu_pkg::ST_WAIT_WB: begin
                    if (wb_ready_i) begin
                        state_q    <= lsu_pkg::ST_WAIT_OP;
                        wb_valid_q <= 1'b0;
                    end
                end
                default: begin
                    state_q <= lsu_pkg::ST_WAIT_OP;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= op_i;
        end
        if ((state_q == lsu_pkg::ST_ACCESS) && issued_q) begin
            wb_req_q.rd   <= op_q.rd;
            // stores never write a register
            wb_req_q.wd   <= op_q.wd && !is_store;
            wb_req_q.data <= result;
        end
    end

    assign wb_req_o   = wb_req_q;
    assign wb_valid_o = wb_valid_q;

endmodule

/* hdl/data_sram.sv */
/* Word-wide data memory with per-byte write enables and a registered read port.
   Read data appears one edge after the read strobe. */
`timescale 1ns/1ps

module data_sram (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       en_i,
    input  logic [3:0]                 we_i,
    input  logic [lsu_pkg::MEM_AW-1:0] addr_i,
    input  lsu_pkg::mem_word_u         wdata_i,
    output lsu_pkg::mem_word_u         rdata_o
);

    lsu_pkg::mem_word_u mem [lsu_pkg::MEM_WORDS];
    lsu_pkg::mem_word_u rdata_q;

    // start from a cleared array in simulation
    initial begin
        for (int i = 0; i < lsu_pkg::MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // only the masked bytes change
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (we_i[b]) begin
                mem[addr_i].lane8[b] <= wdata_i.lane8[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_q <= '0;
        end else if (en_i) begin
            rdata_q <= mem[addr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

/* hdl/lsu_pkg.sv */
/* Shared types and constants for the memory-access stage, data memory and writeback.
   Every block refers to these through lsu_pkg:: scoped names. */
package lsu_pkg;

    // memory and register file sizes
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = 8;
    localparam int REG_NUM   = 32;

    // memory-stage FSM encodings
    localparam logic [1:0] ST_WAIT_OP = 2'd0;
    localparam logic [1:0] ST_ACCESS  = 2'd1;
    localparam logic [1:0] ST_WAIT_WB = 2'd2;

    typedef enum logic [2:0] {
        LOAD_NONE = 3'd0,
        LOAD_LB   = 3'd1,
        LOAD_LH   = 3'd2,
        LOAD_LW   = 3'd3,
        LOAD_LBU  = 3'd4,
        LOAD_LHU  = 3'd5
    } load_type_e;

    typedef enum logic [1:0] {
        STORE_NONE = 2'd0,
        STORE_SB   = 2'd1,
        STORE_SH   = 2'd2,
        STORE_SW   = 2'd3
    } store_type_e;

    // one memory word, viewed by lane or whole
    typedef union packed {
        logic [3:0][7:0]  lane8;
        logic [1:0][15:0] lane16;
        logic [31:0]      word;
    } mem_word_u;

    // operation handed over by execute
    typedef struct packed {
        logic [31:0] addr;
        load_type_e  load_type;
        store_type_e store_type;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        wd;
    } lsu_op_s;

    typedef struct packed {
        logic [4:0]  rd;
        logic        wd;
        logic [31:0] data;
    } wb_req_s;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
    } commit_s;

endpackage
